// File: dv/csr_checker.sv
module csr_checker (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic                          t_gnt_i,
  input logic                          q_gnt_i,
  input logic                          push_i,
  input logic [csr_pkg::CMD_CNT_W-1:0] count_i,
  input logic                          resp_valid_i,
  input logic                          redirect_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // failures so far, summed into the testbench's closing line.
  int assert_errs = 0;

  a_single_grant : assert property (@(posedge clk_i) disable iff (rst_i)
    !(t_gnt_i && q_gnt_i))
    else begin
      assert_errs++;
      $error("trap and queue were granted in the same cycle");
    end

  a_no_push_full : assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> (count_i != csr_pkg::CMD_DEPTH))
    else begin
      assert_errs++;
      $error("command pushed into a full queue");
    end

  a_quiet_after_reset : assert property (@(posedge clk_i)
    rst_i |=> (!resp_valid_i && !redirect_valid_i))
    else begin
      assert_errs++;
      $error("response or redirect valid in the cycle after reset");
    end

endmodule

bind csr_subsystem csr_checker u_checker (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .t_gnt_i          (t_gnt),
  .q_gnt_i          (q_gnt),
  .push_i           (cmd_valid_i),
  .count_i          (u_cmd_queue.count_q),
  .resp_valid_i     (resp_valid_o),
  .redirect_valid_i (redirect_valid_o)
);

// File: dv/csr_tb.sv
module csr_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                           clk_i;
  logic                           rst_i;
  logic                           cmd_valid_i;
  csr_pkg::csr_op_e               cmd_op_i;
  logic [csr_pkg::CSR_ADDR_W-1:0] cmd_addr_i;
  logic [csr_pkg::XLEN-1:0]       cmd_rs1_i;
  logic [csr_pkg::XLEN-1:0]       cmd_imm_i;
  logic                           cmd_we_i;
  logic                           cmd_credit_o;
  logic                           trap_i;
  logic [csr_pkg::XLEN-1:0]       trap_pc_i;
  logic [csr_pkg::XLEN-1:0]       trap_cause_i;
  logic                           trap_busy_o;
  logic                           resp_valid_o;
  logic [csr_pkg::XLEN-1:0]       resp_data_o;
  logic                           redirect_valid_o;
  logic [csr_pkg::XLEN-1:0]       redirect_pc_o;
  logic [csr_pkg::XLEN-1:0]       mie_o;
  logic [csr_pkg::XLEN-1:0]       mepc_o;
  logic [csr_pkg::XLEN-1:0]       mtvec_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table and reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  bit                             tbl_trap  [$];
  csr_pkg::csr_op_e               tbl_op    [$];
  logic [csr_pkg::CSR_ADDR_W-1:0] tbl_addr  [$];
  logic [csr_pkg::XLEN-1:0]       tbl_rs1   [$];
  logic [csr_pkg::XLEN-1:0]       tbl_imm   [$];
  logic                           tbl_we    [$];
  logic [csr_pkg::XLEN-1:0]       tbl_pc    [$];
  logic [csr_pkg::XLEN-1:0]       tbl_cause [$];
  int                             tbl_gap   [$];

  csr_pkg::csr_addr_e all_csrs [5] = '{csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC,
    csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE};

  logic [csr_pkg::XLEN-1:0] m_csr [5];
  int                       m_fifo [$];
  bit                       m_trap_pend;
  logic [csr_pkg::XLEN-1:0] m_trap_pc;
  logic [csr_pkg::XLEN-1:0] m_trap_cause;
  logic [csr_pkg::XLEN-1:0] exp_resp [$];
  logic [csr_pkg::XLEN-1:0] exp_redirect [$];

  int credits;
  int n_cmds = 0;
  int n_traps = 0;
  int n_resp = 0;
  int n_redirect = 0;
  int val_errs = 0;
  int proto_errs = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;
  int idx;
  int gap_left;
  int driven_cmd;
  logic [31:0] rng_state = 32'h1fe2_5941;

  csr_tb_clock u_clock (.clk_o(clk_i));

  csr_subsystem DUT (
    .clk_i (clk_i), .rst_i (rst_i),
    .cmd_valid_i (cmd_valid_i), .cmd_op_i (cmd_op_i), .cmd_addr_i (cmd_addr_i),
    .cmd_rs1_i (cmd_rs1_i), .cmd_imm_i (cmd_imm_i), .cmd_we_i (cmd_we_i),
    .cmd_credit_o (cmd_credit_o),
    .trap_i (trap_i), .trap_pc_i (trap_pc_i), .trap_cause_i (trap_cause_i),
    .trap_busy_o (trap_busy_o),
    .resp_valid_o (resp_valid_o), .resp_data_o (resp_data_o),
    .redirect_valid_o (redirect_valid_o), .redirect_pc_o (redirect_pc_o),
    .mie_o (mie_o), .mepc_o (mepc_o), .mtvec_o (mtvec_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int csr_index(input logic [csr_pkg::CSR_ADDR_W-1:0] addr);
    int i;
    for (i = 0; i < 5; i++) begin
      if (addr == all_csrs[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  // low funct3 bits pick write, set or clear; bit 2 picks the immediate.
  function automatic logic [31:0] op_result(input logic [31:0] old,
      input csr_pkg::csr_op_e op, input logic [31:0] rs1, input logic [31:0] imm);
    logic [31:0] operand;
    operand = op[2] ? imm : rs1;
    case (op[1:0])
      2'd1:    return operand;
      2'd2:    return old | operand;
      2'd3:    return old & ~operand;
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] redirect_target(input logic [31:0] mtvec,
      input logic [31:0] cause);
    logic [31:0] target;
    target = mtvec & 32'hffff_fffc;
    if (mtvec[1:0] == csr_pkg::MTVEC_MODE_VECTORED && cause[31]) begin
      target = target + ((cause & 32'h7fff_ffff) << 2);
    end
    return target;
  endfunction

  task automatic add_cmd(input csr_pkg::csr_op_e op, input logic [11:0] addr,
      input logic [31:0] rs1, input logic [31:0] imm, input logic we, input int gap);
    tbl_trap.push_back(1'b0);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_rs1.push_back(rs1);
    tbl_imm.push_back(imm);
    tbl_we.push_back(we);
    tbl_pc.push_back('0);
    tbl_cause.push_back('0);
    tbl_gap.push_back(gap);
  endtask

  task automatic add_trap(input logic [31:0] pc, input logic [31:0] cause, input int gap);
    add_cmd(csr_pkg::CSR_OP_ZERO, '0, '0, '0, 1'b0, gap);
    tbl_trap[tbl_trap.size()-1] = 1'b1;
    tbl_pc[tbl_pc.size()-1] = pc;
    tbl_cause[tbl_cause.size()-1] = cause;
  endtask

  task automatic add_random_cmd();
    logic [31:0] r;
    logic [11:0] addr;
    r = next_rand();
    addr = (r[6:4] < 3'd5) ? all_csrs[r[6:4]] : 12'h7c0;
    add_cmd(csr_pkg::csr_op_e'(r[2:0]), addr, next_rand(), {27'd0, r[11:7]}, r[3], 0);
  endtask

  task automatic build_table();
    int i;
    // reset values, read with writes masked off.
    for (i = 0; i < 5; i++) begin
      add_cmd(csr_pkg::CSR_OP_RW, all_csrs[i], next_rand(), '0, 1'b0, 0);
    end
    for (i = 0; i < 5; i++) begin
      add_cmd(csr_pkg::CSR_OP_RW, all_csrs[i], next_rand(), '0, 1'b1, 0);
      add_cmd(csr_pkg::CSR_OP_RS, all_csrs[i], '0, '0, 1'b0, 1);
    end
    add_cmd(csr_pkg::CSR_OP_RS, csr_pkg::CSR_MSCRATCH, next_rand(), '0, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RC, csr_pkg::CSR_MSCRATCH, next_rand(), '0, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RSI, csr_pkg::CSR_MSCRATCH, next_rand(), 32'h15, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RCI, csr_pkg::CSR_MSCRATCH, '0, 32'h05, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_ZERO, csr_pkg::CSR_MSCRATCH, next_rand(), '0, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MIE, next_rand(), '0, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_ZEROI, csr_pkg::CSR_MIE, '0, 32'h1f, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RSI, csr_pkg::CSR_MIE, '0, 32'h0a, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RC, csr_pkg::CSR_MIE, 32'hffff_ffff, '0, 1'b0, 0);
    add_cmd(csr_pkg::CSR_OP_RS, csr_pkg::CSR_MIE, '0, '0, 1'b0, 0);
    // unimplemented addresses.
    add_cmd(csr_pkg::CSR_OP_RW, 12'h300, next_rand(), '0, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RSI, 12'h7c0, '0, 32'h1f, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RS, 12'h300, '0, '0, 1'b0, 0);
    // direct mode, then vectored with interrupt and exception causes.
    add_cmd(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MTVEC, 32'h8000_0100, '0, 1'b1, 0);
    add_trap(32'h0000_1234, 32'h8000_0002, 0);
    add_cmd(csr_pkg::CSR_OP_RS, csr_pkg::CSR_MEPC, '0, '0, 1'b0, 0);
    add_cmd(csr_pkg::CSR_OP_RS, csr_pkg::CSR_MCAUSE, '0, '0, 1'b0, 0);
    add_cmd(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MTVEC, 32'h8000_0201, '0, 1'b1, 0);
    add_trap(32'h0000_2000, 32'h8000_0007, 2);
    add_trap(32'h0000_3000, 32'h0000_000b, 0);
    // trap and command land in the same cycle, so commands back up.
    add_trap(32'h0000_4444, 32'h8000_0003, 2);
    add_cmd(csr_pkg::CSR_OP_RS, csr_pkg::CSR_MEPC, '0, '0, 1'b0, 0);
    add_cmd(csr_pkg::CSR_OP_RS, csr_pkg::CSR_MCAUSE, '0, '0, 1'b0, 0);
    add_cmd(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MEPC, next_rand(), '0, 1'b1, 0);
    add_cmd(csr_pkg::CSR_OP_RS, csr_pkg::CSR_MEPC, '0, '0, 1'b0, 0);
    // a trap every other cycle drains the credits.
    for (i = 0; i < 6; i++) begin
      add_trap(next_rand() & 32'hffff_fffc, next_rand(), 0);
      add_random_cmd();
      add_random_cmd();
    end
    for (i = 0; i < 5; i++) begin
      add_cmd(csr_pkg::CSR_OP_RS, all_csrs[i], '0, '0, 1'b0, 0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_resp(input logic [csr_pkg::XLEN-1:0] got,
      input logic [csr_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t: response data %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_redirect(input logic [csr_pkg::XLEN-1:0] got,
      input logic [csr_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t: redirect pc %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_csr(input csr_pkg::csr_addr_e which,
      input logic [csr_pkg::XLEN-1:0] got);
    logic [csr_pkg::XLEN-1:0] exp;
    exp = m_csr[csr_index(which)];
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t: %s output %h, expected %h", $time, which.name(), got, exp);
    end
  endtask

  task automatic note_protocol_error(input string msg);
    proto_errs++;
    $display("%s at time %0t", msg, $time);
  endtask

  // replays the rising edge that just passed, then checks the outputs.
  task automatic model_edge();
    int k;
    int i;
    logic [31:0] old;
    if (m_trap_pend) begin
      exp_redirect.push_back(redirect_target(m_csr[csr_index(csr_pkg::CSR_MTVEC)],
        m_trap_cause));
      m_csr[csr_index(csr_pkg::CSR_MEPC)] = m_trap_pc;
      m_csr[csr_index(csr_pkg::CSR_MCAUSE)] = m_trap_cause;
      m_trap_pend = 1'b0;
    end else if (m_fifo.size() != 0) begin
      k = m_fifo.pop_front();
      i = csr_index(tbl_addr[k]);
      old = '0;
      if (i >= 0) begin
        old = m_csr[i];
        if (tbl_we[k]) begin
          m_csr[i] = op_result(old, tbl_op[k], tbl_rs1[k], tbl_imm[k]);
        end
      end
      exp_resp.push_back(old);
    end
    if (driven_cmd >= 0) begin
      m_fifo.push_back(driven_cmd);
    end
    if (trap_i) begin
      m_trap_pend = 1'b1;
      m_trap_pc = trap_pc_i;
      m_trap_cause = trap_cause_i;
    end
    if (resp_valid_o === 1'b1) begin
      n_resp++;
      if (exp_resp.size() == 0) begin
        note_protocol_error("response arrived with no command outstanding");
      end else begin
        check_resp(resp_data_o, exp_resp.pop_front());
      end
    end
    if (redirect_valid_o === 1'b1) begin
      n_redirect++;
      if (exp_redirect.size() == 0) begin
        note_protocol_error("redirect arrived with no trap outstanding");
      end else begin
        check_redirect(redirect_pc_o, exp_redirect.pop_front());
      end
    end
    if (cmd_credit_o !== resp_valid_o) begin
      note_protocol_error("credit pulse does not match the response");
    end
    if (cmd_credit_o === 1'b1) begin
      credits++;
    end
    if (credits > csr_pkg::CMD_DEPTH) begin
      note_protocol_error("more credits returned than commands sent");
    end
    if (trap_busy_o !== m_trap_pend) begin
      note_protocol_error("trap busy flag does not match the pending trap");
    end
    check_csr(csr_pkg::CSR_MIE, mie_o);
    check_csr(csr_pkg::CSR_MEPC, mepc_o);
    check_csr(csr_pkg::CSR_MTVEC, mtvec_o);
  endtask

  // at most a trap and then a command in one cycle.
  task automatic issue_next();
    cmd_valid_i = 1'b0;
    trap_i = 1'b0;
    driven_cmd = -1;
    if (gap_left > 0) begin
      gap_left--;
    end else begin
      if (idx < tbl_trap.size() && tbl_trap[idx] && !trap_busy_o) begin
        trap_i = 1'b1;
        trap_pc_i = tbl_pc[idx];
        trap_cause_i = tbl_cause[idx];
        n_traps++;
        idx++;
        gap_left = (idx < tbl_trap.size()) ? tbl_gap[idx] : 0;
      end
      if (gap_left == 0 && idx < tbl_trap.size() && !tbl_trap[idx] && credits > 0) begin
        cmd_valid_i = 1'b1;
        cmd_op_i = tbl_op[idx];
        cmd_addr_i = tbl_addr[idx];
        cmd_rs1_i = tbl_rs1[idx];
        cmd_imm_i = tbl_imm[idx];
        cmd_we_i = tbl_we[idx];
        driven_cmd = idx;
        credits--;
        n_cmds++;
        idx++;
        gap_left = (idx < tbl_trap.size()) ? tbl_gap[idx] : 0;
      end
    end
  endtask

  initial begin
    int i;
    rst_i = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_op_i = csr_pkg::CSR_OP_ZERO;
    cmd_addr_i = '0;
    cmd_rs1_i = '0;
    cmd_imm_i = '0;
    cmd_we_i = 1'b0;
    trap_i = 1'b0;
    trap_pc_i = '0;
    trap_cause_i = '0;
    build_table();
    cycle_limit = 20 * tbl_trap.size() + 16;
    for (i = 0; i < 5; i++) begin
      m_csr[i] = '0;
    end
    m_trap_pend = 1'b0;
    credits = csr_pkg::CMD_DEPTH;
    idx = 0;
    gap_left = tbl_gap[0];
    driven_cmd = -1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    do begin
      @(negedge clk_i);
      model_edge();
      issue_next();
    end while (idx < tbl_trap.size() || cmd_valid_i || trap_i || m_fifo.size() != 0 ||
               m_trap_pend);
    if (n_resp != n_cmds) begin
      note_protocol_error($sformatf("%0d responses for %0d commands", n_resp, n_cmds));
    end
    if (n_redirect != n_traps) begin
      note_protocol_error($sformatf("%0d redirects for %0d traps", n_redirect, n_traps));
    end
    if (credits != csr_pkg::CMD_DEPTH) begin
      note_protocol_error($sformatf("sender ends holding %0d credits", credits));
    end
    $display("errors: %0d value, %0d protocol, %0d assertion",
      val_errs, proto_errs, DUT.u_checker.assert_errs);
    if (val_errs + proto_errs + DUT.u_checker.assert_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

endmodule

// File: dv/csr_tb_clock.sv
module csr_tb_clock (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // 100 ns period, first rising edge at 50 ns.
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

endmodule

// File: files.f
rtl/csr_pkg.sv
rtl/csr_cmd_queue.sv
rtl/csr_trap_sequencer.sv
rtl/csr_port_arbiter.sv
rtl/csr_controller.sv
rtl/csr_subsystem.sv
dv/csr_tb_clock.sv
dv/csr_checker.sv
dv/csr_tb.sv

// File: rtl/csr_cmd_queue.sv
module csr_cmd_queue (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                cmd_valid_i,
  input  csr_pkg::csr_op_e                    cmd_op_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]      cmd_addr_i,
  input  logic [csr_pkg::XLEN-1:0]            cmd_rs1_i,
  input  logic [csr_pkg::XLEN-1:0]            cmd_imm_i,
  input  logic                                cmd_we_i,
  output logic                                req_o,
  output csr_pkg::csr_op_e                    op_o,
  output logic [csr_pkg::CSR_ADDR_W-1:0]      addr_o,
  output logic [csr_pkg::XLEN-1:0]            rs1_o,
  output logic [csr_pkg::XLEN-1:0]            imm_o,
  output logic                                we_o,
  input  logic                                gnt_i,
  input  logic [csr_pkg::XLEN-1:0]            rdata_i,
  output logic                                resp_valid_o,
  output logic [csr_pkg::XLEN-1:0]            resp_data_o,
  output logic                                cmd_credit_o
);

  csr_pkg::csr_op_e                   op_mem   [csr_pkg::CMD_DEPTH];
  logic [csr_pkg::CSR_ADDR_W-1:0]     addr_mem [csr_pkg::CMD_DEPTH];
  logic [csr_pkg::XLEN-1:0]           rs1_mem  [csr_pkg::CMD_DEPTH];
  logic [csr_pkg::XLEN-1:0]           imm_mem  [csr_pkg::CMD_DEPTH];
  logic                               we_mem   [csr_pkg::CMD_DEPTH];

  logic [csr_pkg::CMD_PTR_W-1:0] wr_ptr_q;
  logic [csr_pkg::CMD_PTR_W-1:0] rd_ptr_q;
  logic [csr_pkg::CMD_CNT_W-1:0] count_q;
  logic                          push;
  logic                          pop;
  logic                          resp_valid_q;
  logic [csr_pkg::XLEN-1:0]      resp_data_q;

  // the sender only pushes while it holds a credit, so no full check here.
  assign push  = cmd_valid_i;
  assign req_o = (count_q != '0);
  assign pop   = gnt_i & req_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_mem[wr_ptr_q]   <= cmd_op_i;
      addr_mem[wr_ptr_q] <= cmd_addr_i;
      rs1_mem[wr_ptr_q]  <= cmd_rs1_i;
      imm_mem[wr_ptr_q]  <= cmd_imm_i;
      we_mem[wr_ptr_q]   <= cmd_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // head of the fifo.
  assign op_o   = op_mem[rd_ptr_q];
  assign addr_o = addr_mem[rd_ptr_q];
  assign rs1_o  = rs1_mem[rd_ptr_q];
  assign imm_o  = imm_mem[rd_ptr_q];
  assign we_o   = we_mem[rd_ptr_q];

  // response stage, one cycle after the grant.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      resp_data_q <= rdata_i;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;
  // one credit back per entry that leaves.
  assign cmd_credit_o = resp_valid_q;

endmodule

// File: rtl/csr_controller.sv
module csr_controller (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              trap_i,
  input  csr_pkg::csr_op_e                  opcode_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]    addr_i,
  input  logic [csr_pkg::XLEN-1:0]          pc_i,
  input  logic [csr_pkg::XLEN-1:0]          mcause_i,
  input  logic [csr_pkg::XLEN-1:0]          rs1_data_i,
  input  logic [csr_pkg::XLEN-1:0]          imm_data_i,
  input  logic                              write_enable_i,
  output logic [csr_pkg::XLEN-1:0]          read_data_o,
  output logic [csr_pkg::XLEN-1:0]          mie_o,
  output logic [csr_pkg::XLEN-1:0]          mepc_o,
  output logic [csr_pkg::XLEN-1:0]          mtvec_o
);

  logic [csr_pkg::XLEN-1:0] mie_q;
  logic [csr_pkg::XLEN-1:0] mtvec_q;
  logic [csr_pkg::XLEN-1:0] mscratch_q;
  logic [csr_pkg::XLEN-1:0] mepc_q;
  logic [csr_pkg::XLEN-1:0] mcause_q;
  logic [csr_pkg::XLEN-1:0] old_val;
  logic [csr_pkg::XLEN-1:0] new_val;
  logic                     wr_mie;
  logic                     wr_mtvec;
  logic                     wr_mscratch;
  logic                     wr_mepc;
  logic                     wr_mcause;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read mux and operation decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // unimplemented addresses read zero.
  always_comb begin
    case (addr_i)
      csr_pkg::CSR_MIE:      old_val = mie_q;
      csr_pkg::CSR_MTVEC:    old_val = mtvec_q;
      csr_pkg::CSR_MSCRATCH: old_val = mscratch_q;
      csr_pkg::CSR_MEPC:     old_val = mepc_q;
      csr_pkg::CSR_MCAUSE:   old_val = mcause_q;
      default:               old_val = '0;
    endcase
  end

  // codes 0 and 4 clear the register.
  always_comb begin
    case (opcode_i)
      csr_pkg::CSR_OP_RW:  new_val = rs1_data_i;
      csr_pkg::CSR_OP_RS:  new_val = old_val | rs1_data_i;
      csr_pkg::CSR_OP_RC:  new_val = old_val & ~rs1_data_i;
      csr_pkg::CSR_OP_RWI: new_val = imm_data_i;
      csr_pkg::CSR_OP_RSI: new_val = old_val | imm_data_i;
      csr_pkg::CSR_OP_RCI: new_val = old_val & ~imm_data_i;
      default:             new_val = '0;
    endcase
  end

  assign wr_mie      = write_enable_i && (addr_i == csr_pkg::CSR_MIE);
  assign wr_mtvec    = write_enable_i && (addr_i == csr_pkg::CSR_MTVEC);
  assign wr_mscratch = write_enable_i && (addr_i == csr_pkg::CSR_MSCRATCH);
  assign wr_mepc     = write_enable_i && (addr_i == csr_pkg::CSR_MEPC);
  assign wr_mcause   = write_enable_i && (addr_i == csr_pkg::CSR_MCAUSE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
    end else begin
      if (wr_mie) begin
        mie_q <= new_val;
      end
      if (wr_mtvec) begin
        mtvec_q <= new_val;
      end
      if (wr_mscratch) begin
        mscratch_q <= new_val;
      end
    end
  end

  // trap capture wins over a software write.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (trap_i) begin
      mepc_q   <= pc_i;
      mcause_q <= mcause_i;
    end else begin
      if (wr_mepc) begin
        mepc_q <= new_val;
      end
      if (wr_mcause) begin
        mcause_q <= new_val;
      end
    end
  end

  assign read_data_o = old_val;
  assign mie_o       = mie_q;
  assign mepc_o      = mepc_q;
  assign mtvec_o     = mtvec_q;

endmodule

// File: rtl/csr_pkg.sv
package csr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths and sizes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  // queue entries, also the credits the sender starts with.
  localparam int CMD_DEPTH = 4;
  localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
  localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);

  // mode field of mtvec, two low bits.
  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // encodings.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // funct3 codes of the csr instructions.
  typedef enum logic [2:0] {
    CSR_OP_ZERO  = 3'd0,
    CSR_OP_RW    = 3'd1,
    CSR_OP_RS    = 3'd2,
    CSR_OP_RC    = 3'd3,
    CSR_OP_ZEROI = 3'd4,
    CSR_OP_RWI   = 3'd5,
    CSR_OP_RSI   = 3'd6,
    CSR_OP_RCI   = 3'd7
  } csr_op_e;

  // implemented machine-mode addresses.
  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342
  } csr_addr_e;

endpackage

// File: rtl/csr_port_arbiter.sv
module csr_port_arbiter (
  input  logic                              t_req_i,
  input  logic [csr_pkg::XLEN-1:0]          t_pc_i,
  input  logic [csr_pkg::XLEN-1:0]          t_cause_i,
  input  logic                              q_req_i,
  input  csr_pkg::csr_op_e                  q_op_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]    q_addr_i,
  input  logic [csr_pkg::XLEN-1:0]          q_rs1_i,
  input  logic [csr_pkg::XLEN-1:0]          q_imm_i,
  input  logic                              q_we_i,
  output logic                              t_gnt_o,
  output logic                              q_gnt_o,
  output csr_pkg::csr_op_e                  op_o,
  output logic [csr_pkg::CSR_ADDR_W-1:0]    addr_o,
  output logic [csr_pkg::XLEN-1:0]          rs1_o,
  output logic [csr_pkg::XLEN-1:0]          imm_o,
  output logic                              we_o,
  output logic                              trap_o,
  output logic [csr_pkg::XLEN-1:0]          pc_o,
  output logic [csr_pkg::XLEN-1:0]          cause_o
);

  // trap always wins.
  assign t_gnt_o = t_req_i;
  assign q_gnt_o = q_req_i & ~t_req_i;

  always_comb begin
    op_o    = csr_pkg::CSR_OP_ZERO;
    addr_o  = '0;
    rs1_o   = '0;
    imm_o   = '0;
    we_o    = 1'b0;
    trap_o  = 1'b0;
    pc_o    = '0;
    cause_o = '0;
    if (t_gnt_o) begin
      trap_o  = 1'b1;
      pc_o    = t_pc_i;
      cause_o = t_cause_i;
    end else if (q_gnt_o) begin
      op_o   = q_op_i;
      addr_o = q_addr_i;
      rs1_o  = q_rs1_i;
      imm_o  = q_imm_i;
      we_o   = q_we_i;
    end
  end

endmodule

// File: rtl/csr_subsystem.sv
module csr_subsystem (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              cmd_valid_i,
  input  csr_pkg::csr_op_e                  cmd_op_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]    cmd_addr_i,
  input  logic [csr_pkg::XLEN-1:0]          cmd_rs1_i,
  input  logic [csr_pkg::XLEN-1:0]          cmd_imm_i,
  input  logic                              cmd_we_i,
  output logic                              cmd_credit_o,
  input  logic                              trap_i,
  input  logic [csr_pkg::XLEN-1:0]          trap_pc_i,
  input  logic [csr_pkg::XLEN-1:0]          trap_cause_i,
  output logic                              trap_busy_o,
  output logic                              resp_valid_o,
  output logic [csr_pkg::XLEN-1:0]          resp_data_o,
  output logic                              redirect_valid_o,
  output logic [csr_pkg::XLEN-1:0]          redirect_pc_o,
  output logic [csr_pkg::XLEN-1:0]          mie_o,
  output logic [csr_pkg::XLEN-1:0]          mepc_o,
  output logic [csr_pkg::XLEN-1:0]          mtvec_o
);

  // queue side.
  logic                            q_req;
  logic                            q_gnt;
  csr_pkg::csr_op_e                q_op;
  logic [csr_pkg::CSR_ADDR_W-1:0]  q_addr;
  logic [csr_pkg::XLEN-1:0]        q_rs1;
  logic [csr_pkg::XLEN-1:0]        q_imm;
  logic                            q_we;

  // trap side.
  logic                            t_req;
  logic                            t_gnt;
  logic [csr_pkg::XLEN-1:0]        t_pc;
  logic [csr_pkg::XLEN-1:0]        t_cause;

  // shared port into the csr file.
  csr_pkg::csr_op_e                csr_op;
  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_addr;
  logic [csr_pkg::XLEN-1:0]        csr_rs1;
  logic [csr_pkg::XLEN-1:0]        csr_imm;
  logic                            csr_we;
  logic                            csr_trap;
  logic [csr_pkg::XLEN-1:0]        csr_pc;
  logic [csr_pkg::XLEN-1:0]        csr_cause;
  logic [csr_pkg::XLEN-1:0]        csr_rdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // requesters.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  csr_cmd_queue u_cmd_queue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_rs1_i    (cmd_rs1_i),
    .cmd_imm_i    (cmd_imm_i),
    .cmd_we_i     (cmd_we_i),
    .req_o        (q_req),
    .op_o         (q_op),
    .addr_o       (q_addr),
    .rs1_o        (q_rs1),
    .imm_o        (q_imm),
    .we_o         (q_we),
    .gnt_i        (q_gnt),
    .rdata_i      (csr_rdata),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o),
    .cmd_credit_o (cmd_credit_o)
  );

  csr_trap_sequencer u_trap_seq (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .trap_i           (trap_i),
    .trap_pc_i        (trap_pc_i),
    .trap_cause_i     (trap_cause_i),
    .mtvec_i          (mtvec_o),
    .req_o            (t_req),
    .pc_o             (t_pc),
    .cause_o          (t_cause),
    .gnt_i            (t_gnt),
    .busy_o           (trap_busy_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arbitration and csr file.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  csr_port_arbiter u_arbiter (
    .t_req_i   (t_req),
    .t_pc_i    (t_pc),
    .t_cause_i (t_cause),
    .q_req_i   (q_req),
    .q_op_i    (q_op),
    .q_addr_i  (q_addr),
    .q_rs1_i   (q_rs1),
    .q_imm_i   (q_imm),
    .q_we_i    (q_we),
    .t_gnt_o   (t_gnt),
    .q_gnt_o   (q_gnt),
    .op_o      (csr_op),
    .addr_o    (csr_addr),
    .rs1_o     (csr_rs1),
    .imm_o     (csr_imm),
    .we_o      (csr_we),
    .trap_o    (csr_trap),
    .pc_o      (csr_pc),
    .cause_o   (csr_cause)
  );

  csr_controller u_csr (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .trap_i         (csr_trap),
    .opcode_i       (csr_op),
    .addr_i         (csr_addr),
    .pc_i           (csr_pc),
    .mcause_i       (csr_cause),
    .rs1_data_i     (csr_rs1),
    .imm_data_i     (csr_imm),
    .write_enable_i (csr_we),
    .read_data_o    (csr_rdata),
    .mie_o          (mie_o),
    .mepc_o         (mepc_o),
    .mtvec_o        (mtvec_o)
  );

endmodule

// File: rtl/csr_trap_sequencer.sv
module csr_trap_sequencer (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       trap_i,
  input  logic [csr_pkg::XLEN-1:0]   trap_pc_i,
  input  logic [csr_pkg::XLEN-1:0]   trap_cause_i,
  input  logic [csr_pkg::XLEN-1:0]   mtvec_i,
  output logic                       req_o,
  output logic [csr_pkg::XLEN-1:0]   pc_o,
  output logic [csr_pkg::XLEN-1:0]   cause_o,
  input  logic                       gnt_i,
  output logic                       busy_o,
  output logic                       redirect_valid_o,
  output logic [csr_pkg::XLEN-1:0]   redirect_pc_o
);

  typedef enum logic {
    TRAP_IDLE,
    TRAP_PENDING
  } trap_state_e;

  trap_state_e                state_q;
  logic [csr_pkg::XLEN-1:0]   pc_q;
  logic [csr_pkg::XLEN-1:0]   cause_q;
  logic [csr_pkg::XLEN-1:0]   target;
  logic                       redirect_valid_q;
  logic [csr_pkg::XLEN-1:0]   redirect_pc_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= TRAP_IDLE;
    end else begin
      case (state_q)
        TRAP_IDLE:    if (trap_i) state_q <= TRAP_PENDING;
        TRAP_PENDING: if (gnt_i) state_q <= TRAP_IDLE;
        default:      state_q <= TRAP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (trap_i && state_q == TRAP_IDLE) begin
      pc_q    <= trap_pc_i;
      cause_q <= trap_cause_i;
    end
  end

  assign req_o   = (state_q == TRAP_PENDING);
  assign busy_o  = req_o;
  assign pc_o    = pc_q;
  assign cause_o = cause_q;

  // base with mode bits cleared, plus 4*cause for vectored interrupts.
  always_comb begin
    target = {mtvec_i[csr_pkg::XLEN-1:2], 2'b00};
    if (mtvec_i[1:0] == csr_pkg::MTVEC_MODE_VECTORED && cause_q[csr_pkg::XLEN-1]) begin
      target = target + {cause_q[csr_pkg::XLEN-3:0], 2'b00};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      redirect_valid_q <= 1'b0;
    end else begin
      redirect_valid_q <= gnt_i & req_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_i && req_o) begin
      redirect_pc_q <= target;
    end
  end

  assign redirect_valid_o = redirect_valid_q;
  assign redirect_pc_o    = redirect_pc_q;

endmodule
